// ==== Makefile ====
# Verilator build and run for the rtos kernel core testbench

TOP = rtos_core_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): project.f $(wildcard logic/*.sv logic/*.svh dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

# exit status of the simulation is the pass or fail result
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== dv/rtos_core_checker.sv ====
// rtos core checker
// concurrent assertions on the core's top-level ports, bound into rtos_core

`timescale 1ns/100ps
`default_nettype none

`include "rtos_consts.svh"

module rtos_core_checker (
    input logic                     clk,
    input logic                     rst_n,
    input rtos_pkg::tskid_t         run_tskid,
    input logic [`RTOS_TSKID_W-1:0] rdq_count,
    input rtos_pkg::pol_rsp_t       pol_rsp,
    input logic                     time_tick
);

    // empty ready set means no running task
    a_run_vs_count: assert property (
        @(posedge clk) disable iff (!rst_n)
        (run_tskid == '0) == (rdq_count == '0)
    ) else $error("run_tskid and rdq_count disagree about an empty ready set");

    a_tick_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        time_tick |=> !time_tick
    ) else $error("time_tick high in two consecutive cycles");

    // sync reset clears the poll response at the next edge
    a_pol_reset: assert property (
        @(posedge clk)
        !rst_n |=> !pol_rsp.valid
    ) else $error("pol_rsp.valid high during reset");

endmodule

bind rtos_core rtos_core_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .run_tskid (run_tskid),
    .rdq_count (rdq_count),
    .pol_rsp   (pol_rsp),
    .time_tick (time_tick)
);

`default_nettype wire

// ==== dv/rtos_core_tb.sv ====
// rtos kernel core testbench
// replays the command file through a credit-tracking driver, drains
// the pipeline at each check step and compares the visible state

`timescale 1ns/100ps
`default_nettype none

`include "rtos_consts.svh"

module rtos_core_tb;

    localparam int          CLK_HALF  = 4;
    localparam int          WORDS     = 8;
    localparam int          MAX_LINES = 64;
    localparam int          LINE_CYC  = 200;
    localparam logic [15:0] OP_END    = 16'h000f;

    logic                                    clk = 1'b0;
    logic                                    rst_n;
    rtos_pkg::rtos_cmd_t                     cmd;
    logic                                    credit_return;
    logic                                    busy;
    rtos_pkg::tskid_t                        run_tskid;
    logic [`RTOS_TSKID_W-1:0]                rdq_count;
    rtos_pkg::tskstat_e [`RTOS_TMAX_TSKID:1] tskstat;
    rtos_pkg::semcnt_t [`RTOS_TMAX_SEMID:1]  semcnt;
    rtos_pkg::pol_rsp_t                      pol_rsp;
    logic                                    time_tick;

    logic [15:0]        stim_mem [WORDS*MAX_LINES];
    int                 n_lines;
    int                 cur_line;
    int                 sent;
    int                 returned;
    int                 pol_seen;
    int                 pol_snap;
    rtos_pkg::pol_rsp_t pol_last;
    int                 cycle_cnt;
    int                 last_tick;
    logic [31:0]        rng_state;

    rtos_core uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd           (cmd),
        .credit_return (credit_return),
        .busy          (busy),
        .run_tskid     (run_tskid),
        .rdq_count     (rdq_count),
        .tskstat       (tskstat),
        .semcnt        (semcnt),
        .pol_rsp       (pol_rsp),
        .time_tick     (time_tick)
    );

    always #CLK_HALF clk = ~clk;

    // --------------------
    // helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int credits_held();
        return `RTOS_CMD_DEPTH - sent + returned;
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_tskid(input rtos_pkg::tskid_t got, input rtos_pkg::tskid_t exp);
        if (got !== exp) begin
            $display("ERR %0t: step %0d run_tskid %0d, expected %0d",
                     $time, cur_line, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_count(input logic [`RTOS_TSKID_W-1:0] got,
                                 input logic [`RTOS_TSKID_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: step %0d rdq_count %0d, expected %0d",
                     $time, cur_line, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_state(input int id, input rtos_pkg::tskstat_e got,
                                 input rtos_pkg::tskstat_e exp);
        if (got !== exp) begin
            $display("ERR %0t: step %0d task %0d state %s, expected %s",
                     $time, cur_line, id, got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic compare_semcnt(input int id, input rtos_pkg::semcnt_t got,
                                  input rtos_pkg::semcnt_t exp);
        if (got !== exp) begin
            $display("ERR %0t: step %0d semaphore %0d count %0d, expected %0d",
                     $time, cur_line, id, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_poll(input rtos_pkg::pol_rsp_t got, input rtos_pkg::pol_rsp_t exp);
        if (got !== exp) begin
            $display("ERR %0t: step %0d poll ack %0b, expected %0b",
                     $time, cur_line, got.ack, exp.ack);
            abort_run();
        end
    endtask

    task automatic compare_int(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %0t: step %0d %s is %0d, expected %0d",
                     $time, cur_line, what, got, exp);
            abort_run();
        end
    endtask

    // one command on the falling edge, optional random gap first
    task automatic send_cmd(input logic [15:0] op, input logic [15:0] arg, input logic gap);
        int idle;
        if (gap) begin
            rng_state = xorshift32(rng_state);
            idle      = int'(rng_state[1:0]);
            repeat (idle) @(negedge clk);
        end
        while (credits_held() == 0) begin
            @(negedge clk);
        end
        cmd.valid  = 1'b1;
        cmd.op     = rtos_pkg::rtos_op_e'(op[2:0]);
        cmd.tskid  = arg[`RTOS_TSKID_W-1:0];
        cmd.semid  = arg[`RTOS_SEMID_W-1:0];
        cmd.dlytim = arg[`RTOS_RELTIM_W-1:0];
        sent       = sent + 1;
        @(negedge clk);
        cmd = '0;
    endtask

    task automatic drain_and_compare(input int base);
        logic [15:0]        stat_w;
        logic [15:0]        sem_w;
        logic [15:0]        pol_w;
        rtos_pkg::pol_rsp_t pol_exp;
        @(negedge clk);
        while (busy || (credits_held() < `RTOS_CMD_DEPTH)) begin
            @(negedge clk);
        end
        stat_w = stim_mem[base+5];
        sem_w  = stim_mem[base+6];
        pol_w  = stim_mem[base+7];
        compare_int("held credits", credits_held(), `RTOS_CMD_DEPTH);
        compare_tskid(run_tskid, stim_mem[base+3][`RTOS_TSKID_W-1:0]);
        compare_count(rdq_count, stim_mem[base+4][`RTOS_TSKID_W-1:0]);
        for (int i = 1; i <= `RTOS_TMAX_TSKID; i++) begin
            compare_state(i, tskstat[i], rtos_pkg::tskstat_e'(stat_w[2*i-2 +: 2]));
        end
        for (int s = 1; s <= `RTOS_TMAX_SEMID; s++) begin
            compare_semcnt(s, semcnt[s], sem_w[4*s-4 +: 4]);
        end
        // 2 means no poll to check at this step
        if (pol_w != 16'h2) begin
            if (pol_seen == pol_snap) begin
                $display("step %0d expected a poll response but none came", cur_line);
                abort_run();
            end
            pol_exp.valid = 1'b1;
            pol_exp.ack   = pol_w[0];
            compare_poll(pol_last, pol_exp);
        end
        pol_snap = pol_seen;
    endtask

    // --------------------
    // monitors

    always @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
            if (credit_return) begin
                returned <= returned + 1;
            end
            if (pol_rsp.valid) begin
                pol_last <= pol_rsp;
                pol_seen <= pol_seen + 1;
            end
        end
    end

    // tick spacing, first pulse counted from reset release
    always @(negedge clk) begin
        if (rst_n && time_tick) begin
            compare_int("tick interval", cycle_cnt - last_tick, `RTOS_PRESCALE);
            last_tick = cycle_cnt;
        end
    end

    initial begin : watchdog
        wait (n_lines > 0);
        repeat (n_lines * LINE_CYC + 8) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", n_lines * LINE_CYC);
        abort_run();
    end

    // --------------------
    // stimulus

    initial begin : stimulus
        int          base;
        int          count;
        logic [15:0] op;
        logic [15:0] arg;
        logic [15:0] flag;
        rst_n     = 1'b0;
        cmd       = '0;
        rng_state = 32'h60c1;
        for (int i = 0; i < WORDS * MAX_LINES; i++) begin
            stim_mem[i] = OP_END;
        end
        $readmemh("dv/rtos_stim.txt", stim_mem);
        count = 0;
        while ((count < MAX_LINES) && (stim_mem[count*WORDS] != OP_END)) begin
            count = count + 1;
        end
        if (count == 0) begin
            $display("no stimulus steps found in dv/rtos_stim.txt");
            abort_run();
        end
        n_lines = count;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        for (int ln = 0; ln < n_lines; ln++) begin
            base     = ln * WORDS;
            cur_line = ln + 1;
            op       = stim_mem[base];
            arg      = stim_mem[base+1];
            flag     = stim_mem[base+2];
            if (op == 16'h0) begin
                repeat (arg) @(negedge clk);
            end else begin
                send_cmd(op, arg, !flag[1]);
            end
            if (flag[0]) begin
                drain_and_compare(base);
            end
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/rtos_stim.txt ====
// op arg flag run cnt stat sem pol, all hex; op 0 idles arg cycles, op f ends
// flag bit0 drains and checks, bit1 sends without a gap; pol 2 skips the ack
0 0 1 1 7 0000 000 2
2 0 1 2 6 0001 000 2
2 0 1 3 5 0005 000 2
1 1 1 1 6 0004 000 2
1 1 0 0 0 0000 000 2
2 0 1 1 6 0004 000 2
2 0 1 3 5 0005 000 2
1 2 0 0 0 0000 000 2
1 1 1 1 7 0000 000 2
4 1 0 0 0 0000 000 2
4 1 1 1 7 0000 002 2
6 1 0 0 0 0000 000 2
6 1 1 1 7 0000 000 1
6 1 1 1 7 0000 000 0
5 2 0 0 0 0000 000 2
5 2 1 3 5 000f 000 2
4 2 1 1 6 000c 000 2
4 2 1 1 7 0000 000 2
3 3 1 2 6 0002 000 2
0 28 1 1 7 0000 000 2
3 0 1 1 7 0000 000 2
4 1 2 0 0 0000 000 2
4 2 2 0 0 0000 000 2
4 3 2 0 0 0000 000 2
4 1 3 1 7 0000 112 2
2 0 2 0 0 0000 000 2
2 0 2 0 0 0000 000 2
5 1 2 0 0 0000 000 2
1 1 3 1 6 0004 111 2
6 1 2 0 0 0000 000 2
6 2 2 0 0 0000 000 2
1 2 2 0 0 0000 000 2
4 3 2 0 0 0000 000 2
6 1 3 1 7 0000 200 0
3 2 1 2 6 0002 200 2
0 1e 1 1 7 0000 200 2
f 0 0 0 0 0000 000 0

// ==== logic/rtos_cmd_queue.sv ====
// rtos command queue
// credit-flow command FIFO; returns one credit per entry that leaves
// and holds commands on the running task until the pipeline has drained

`timescale 1ns/100ps
`default_nettype none

`include "rtos_consts.svh"

module rtos_cmd_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  rtos_pkg::rtos_cmd_t cmd,
    input  logic                stage_busy,
    output rtos_pkg::rtos_cmd_t issue,
    output logic                credit_return,
    output logic                queue_busy
);

    localparam int PTR_W = $clog2(`RTOS_CMD_DEPTH);

    rtos_pkg::rtos_cmd_t fifo_mem [`RTOS_CMD_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      fill;
    logic                stage_busy_q;

    rtos_pkg::rtos_cmd_t head;
    logic                head_valid;
    logic                run_dep;
    logic                hold;
    logic                pop;

    // --------------------
    // head and interlock

    assign head       = fifo_mem[rd_ptr];
    assign head_valid = (fill != '0);

    // ops that act on run_tskid
    assign run_dep = (head.op == rtos_pkg::SLP_TSK) ||
                     (head.op == rtos_pkg::DLY_TSK) ||
                     (head.op == rtos_pkg::WAI_SEM);

    // extra cycle lets run_tskid settle after the last rdq update
    assign hold = run_dep && (stage_busy || stage_busy_q);
    assign pop  = head_valid && !hold;

    assign issue         = pop ? head : '0;
    assign credit_return = pop;
    assign queue_busy    = head_valid;

    // --------------------
    // storage

    always_ff @(posedge clk) begin
        if (cmd.valid) begin
            fifo_mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fill         <= '0;
            stage_busy_q <= 1'b0;
        end else begin
            stage_busy_q <= stage_busy;
            if (cmd.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill <= fill + {{PTR_W{1'b0}}, cmd.valid} - {{PTR_W{1'b0}}, pop};
        end
    end

endmodule

`default_nettype wire

// ==== logic/rtos_consts.svh ====
// rtos kernel core constants
// task and semaphore counts, field widths, command queue depth and
// the tick prescale shared by every stage

`ifndef RTOS_CONSTS_SVH
`define RTOS_CONSTS_SVH

// object counts
`define RTOS_TMAX_TSKID 7
`define RTOS_TMAX_SEMID 3

// command FIFO depth, also the host's initial credits
`define RTOS_CMD_DEPTH 4

// clock cycles per time tick
`define RTOS_PRESCALE 10

// field widths
`define RTOS_TSKID_W 3
`define RTOS_SEMID_W 2
`define RTOS_SEMCNT_W 4
`define RTOS_RELTIM_W 8

`endif

// ==== logic/rtos_core.sv ====
// rtos kernel core, scheduling path
// command queue, object stage, task table and ready queue in a
// four stage pipeline

`timescale 1ns/100ps
`default_nettype none

`include "rtos_consts.svh"

module rtos_core (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  rtos_pkg::rtos_cmd_t                       cmd,
    output logic                                      credit_return,
    output logic                                      busy,
    output rtos_pkg::tskid_t                          run_tskid,
    output logic [`RTOS_TSKID_W-1:0]                  rdq_count,
    output rtos_pkg::tskstat_e [`RTOS_TMAX_TSKID:1]   tskstat,
    output rtos_pkg::semcnt_t [`RTOS_TMAX_SEMID:1]    semcnt,
    output rtos_pkg::pol_rsp_t                        pol_rsp,
    output logic                                      time_tick
);

    rtos_pkg::rtos_cmd_t issue;
    rtos_pkg::task_evt_t evt;
    rtos_pkg::rdq_op_t   rdq;
    logic                queue_busy;
    logic                obj_busy;
    logic                task_busy;

    assign busy = queue_busy || obj_busy || task_busy;

    // --------------------
    // pipeline

    rtos_cmd_queue i_cmd_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd           (cmd),
        .stage_busy    (obj_busy || task_busy),
        .issue         (issue),
        .credit_return (credit_return),
        .queue_busy    (queue_busy)
    );

    rtos_object_stage i_object_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .run_tskid (run_tskid),
        .evt       (evt),
        .pol_rsp   (pol_rsp),
        .semcnt    (semcnt),
        .obj_busy  (obj_busy)
    );

    rtos_task_table i_task_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .evt       (evt),
        .rdq       (rdq),
        .tskstat   (tskstat),
        .time_tick (time_tick),
        .task_busy (task_busy)
    );

    rtos_ready_queue i_ready_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .rdq       (rdq),
        .run_tskid (run_tskid),
        .rdq_count (rdq_count)
    );

endmodule

`default_nettype wire

// ==== logic/rtos_object_stage.sv ====
// rtos object stage
// counting semaphores with their waiter sets; turns each issued
// command into a task event and answers semaphore polls

`timescale 1ns/100ps
`default_nettype none

`include "rtos_consts.svh"

module rtos_object_stage (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  rtos_pkg::rtos_cmd_t                              issue,
    input  rtos_pkg::tskid_t                                 run_tskid,
    output rtos_pkg::task_evt_t                              evt,
    output rtos_pkg::pol_rsp_t                               pol_rsp,
    output rtos_pkg::semcnt_t [`RTOS_TMAX_SEMID:1]           semcnt,
    output logic                                             obj_busy
);

    rtos_pkg::tsk_mask_t [`RTOS_TMAX_SEMID:1] sem_wait;

    logic                run_ok;
    logic                sem_ok;
    rtos_pkg::semcnt_t   cur_cnt;
    rtos_pkg::tsk_mask_t cur_wait;
    rtos_pkg::tskid_t    wake_id;
    rtos_pkg::tsk_mask_t wup_mask;

    assign run_ok   = (run_tskid != '0);
    assign sem_ok   = (issue.semid != '0);
    assign cur_cnt  = semcnt[issue.semid];
    assign cur_wait = sem_wait[issue.semid];
    assign wake_id  = rtos_pkg::first_tskid(cur_wait);
    assign wup_mask = rtos_pkg::tskid_mask(issue.tskid);

    assign obj_busy = (evt.kind != rtos_pkg::EVT_NONE) || pol_rsp.valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            semcnt   <= '0;
            sem_wait <= '0;
            evt      <= '0;
            pol_rsp  <= '0;
        end else begin
            evt           <= '0;
            pol_rsp.valid <= 1'b0;
            if (issue.valid) begin
                case (issue.op)
                    rtos_pkg::WUP_TSK: begin
                        if (issue.tskid != '0) begin
                            evt <= '{kind: rtos_pkg::EVT_WAKE, tskid: issue.tskid, dlytim: '0};
                            // a woken task no longer waits anywhere
                            for (int s = 1; s <= `RTOS_TMAX_SEMID; s++) begin
                                sem_wait[s] <= sem_wait[s] & ~wup_mask;
                            end
                        end
                    end
                    rtos_pkg::SLP_TSK: begin
                        if (run_ok) begin
                            evt <= '{kind: rtos_pkg::EVT_SLEEP, tskid: run_tskid, dlytim: '0};
                        end
                    end
                    rtos_pkg::DLY_TSK: begin
                        if (run_ok) begin
                            evt <= '{kind: rtos_pkg::EVT_DELAY, tskid: run_tskid,
                                     dlytim: issue.dlytim};
                        end
                    end
                    rtos_pkg::SIG_SEM: begin
                        if (sem_ok) begin
                            if (cur_wait != '0) begin
                                // release lowest id waiter
                                sem_wait[issue.semid] <= cur_wait &
                                                         ~rtos_pkg::tskid_mask(wake_id);
                                evt <= '{kind: rtos_pkg::EVT_WAKE, tskid: wake_id, dlytim: '0};
                            end else if (cur_cnt != '1) begin
                                semcnt[issue.semid] <= cur_cnt + 1'b1;
                            end
                        end
                    end
                    rtos_pkg::WAI_SEM: begin
                        if (sem_ok && run_ok) begin
                            if (cur_cnt != '0) begin
                                semcnt[issue.semid] <= cur_cnt - 1'b1;
                            end else begin
                                sem_wait[issue.semid] <= cur_wait |
                                                         rtos_pkg::tskid_mask(run_tskid);
                                evt <= '{kind: rtos_pkg::EVT_WAIT, tskid: run_tskid, dlytim: '0};
                            end
                        end
                    end
                    rtos_pkg::POL_SEM: begin
                        pol_rsp.valid <= 1'b1;
                        pol_rsp.ack   <= sem_ok && (cur_cnt != '0);
                        if (sem_ok && (cur_cnt != '0)) begin
                            semcnt[issue.semid] <= cur_cnt - 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/rtos_pkg.sv ====
// rtos kernel core types
// ids, masks, operation and state encodings, and the structs that
// carry commands and events between the pipeline stages

`default_nettype none

`include "rtos_consts.svh"

package rtos_pkg;

    typedef logic [`RTOS_TSKID_W-1:0]    tskid_t;
    typedef logic [`RTOS_TMAX_TSKID-1:0] tsk_mask_t;
    typedef logic [`RTOS_SEMID_W-1:0]    semid_t;
    typedef logic [`RTOS_SEMCNT_W-1:0]   semcnt_t;
    typedef logic [`RTOS_RELTIM_W-1:0]   reltim_t;

    typedef enum logic [2:0] {
        NOP     = 3'd0,
        WUP_TSK = 3'd1,
        SLP_TSK = 3'd2,
        DLY_TSK = 3'd3,
        SIG_SEM = 3'd4,
        WAI_SEM = 3'd5,
        POL_SEM = 3'd6
    } rtos_op_e;

    typedef enum logic [1:0] {
        READY    = 2'd0,
        SLEEP    = 2'd1,
        WAIT_DLY = 2'd2,
        WAIT_SEM = 2'd3
    } tskstat_e;

    typedef enum logic [2:0] {
        EVT_NONE  = 3'd0,
        EVT_WAKE  = 3'd1,
        EVT_SLEEP = 3'd2,
        EVT_DELAY = 3'd3,
        EVT_WAIT  = 3'd4
    } task_evt_e;

    typedef struct packed {
        logic     valid;
        rtos_op_e op;
        tskid_t   tskid;
        semid_t   semid;
        reltim_t  dlytim;
    } rtos_cmd_t;

    typedef struct packed {
        task_evt_e kind;
        tskid_t    tskid;
        reltim_t   dlytim;
    } task_evt_t;

    typedef struct packed {
        tsk_mask_t set;
        tsk_mask_t clr;
    } rdq_op_t;

    typedef struct packed {
        logic valid;
        logic ack;
    } pol_rsp_t;

    // lowest task id present in a mask, 0 when empty
    function automatic tskid_t first_tskid(tsk_mask_t m);
        tskid_t id;
        id = '0;
        for (int i = `RTOS_TMAX_TSKID; i >= 1; i--) begin
            if (m[i-1]) begin
                id = tskid_t'(i);
            end
        end
        return id;
    endfunction

    // one-hot mask for a task id, empty for id 0
    function automatic tsk_mask_t tskid_mask(tskid_t id);
        tsk_mask_t m;
        m = '0;
        if (id != '0) begin
            m[id - 1'b1] = 1'b1;
        end
        return m;
    endfunction

endpackage

`default_nettype wire

// ==== logic/rtos_ready_queue.sv ====
// rtos ready queue
// holds the ready set and registers the running task, which is the
// lowest ready id, together with the number of ready tasks

`timescale 1ns/100ps
`default_nettype none

`include "rtos_consts.svh"

module rtos_ready_queue (
    input  logic                       clk,
    input  logic                       rst_n,
    input  rtos_pkg::rdq_op_t          rdq,
    output rtos_pkg::tskid_t           run_tskid,
    output logic [`RTOS_TSKID_W-1:0]   rdq_count
);

    localparam logic [`RTOS_TSKID_W-1:0] ALL_READY_CNT = `RTOS_TMAX_TSKID;

    rtos_pkg::tsk_mask_t          ready;
    rtos_pkg::tsk_mask_t          ready_nxt;
    logic [`RTOS_TSKID_W-1:0]     ready_cnt;

    // clear first, so a set in the same cycle wins
    assign ready_nxt = (ready & ~rdq.clr) | rdq.set;

    // --------------------
    // population count

    always_comb begin : blk_count
        ready_cnt = '0;
        for (int i = 0; i < `RTOS_TMAX_TSKID; i++) begin
            if (ready_nxt[i]) begin
                ready_cnt = ready_cnt + 1'b1;
            end
        end
    end

    // --------------------
    // registers

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready     <= '1;
            run_tskid <= rtos_pkg::tskid_t'(1);
            rdq_count <= ALL_READY_CNT;
        end else begin
            ready     <= ready_nxt;
            run_tskid <= rtos_pkg::first_tskid(ready_nxt);
            rdq_count <= ready_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rtos_task_table.sv ====
// rtos task table
// per-task state, wake-up count and delay counter plus the tick
// prescaler; every state change goes out as ready set/clear masks

`timescale 1ns/100ps
`default_nettype none

`include "rtos_consts.svh"

module rtos_task_table (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  rtos_pkg::task_evt_t                       evt,
    output rtos_pkg::rdq_op_t                         rdq,
    output rtos_pkg::tskstat_e [`RTOS_TMAX_TSKID:1]   tskstat,
    output logic                                      time_tick,
    output logic                                      task_busy
);

    localparam int PSCL_W = $clog2(`RTOS_PRESCALE);

    logic [`RTOS_TMAX_TSKID:1]                wupcnt;
    rtos_pkg::reltim_t [`RTOS_TMAX_TSKID:1]   dlycnt;
    logic [PSCL_W-1:0]                        pscl_cnt;

    rtos_pkg::tskstat_e [`RTOS_TMAX_TSKID:1]  stat_nxt;
    logic [`RTOS_TMAX_TSKID:1]                wup_nxt;
    rtos_pkg::reltim_t [`RTOS_TMAX_TSKID:1]   dly_nxt;
    rtos_pkg::tsk_mask_t                      set_nxt;
    rtos_pkg::tsk_mask_t                      clr_nxt;

    assign task_busy = (rdq.set != '0) || (rdq.clr != '0);

    // --------------------
    // next task state

    always_comb begin : blk_next
        stat_nxt = tskstat;
        wup_nxt  = wupcnt;
        dly_nxt  = dlycnt;
        set_nxt  = '0;
        clr_nxt  = '0;
        for (int i = 1; i <= `RTOS_TMAX_TSKID; i++) begin
            if (time_tick && (tskstat[i] == rtos_pkg::WAIT_DLY)) begin
                dly_nxt[i] = dlycnt[i] - 1'b1;
                if (dlycnt[i] == rtos_pkg::reltim_t'(1)) begin
                    stat_nxt[i]  = rtos_pkg::READY;
                    set_nxt[i-1] = 1'b1;
                end
            end
            // a command event wins over an expiring delay
            if (evt.tskid == rtos_pkg::tskid_t'(i)) begin
                case (evt.kind)
                    rtos_pkg::EVT_WAKE: begin
                        if ((tskstat[i] == rtos_pkg::SLEEP) ||
                            (tskstat[i] == rtos_pkg::WAIT_SEM)) begin
                            stat_nxt[i]  = rtos_pkg::READY;
                            set_nxt[i-1] = 1'b1;
                        end else begin
                            wup_nxt[i] = 1'b1;
                        end
                    end
                    rtos_pkg::EVT_SLEEP: begin
                        if (wupcnt[i]) begin
                            wup_nxt[i] = 1'b0;
                        end else begin
                            stat_nxt[i]  = rtos_pkg::SLEEP;
                            set_nxt[i-1] = 1'b0;
                            clr_nxt[i-1] = 1'b1;
                        end
                    end
                    rtos_pkg::EVT_DELAY: begin
                        if (evt.dlytim != '0) begin
                            stat_nxt[i]  = rtos_pkg::WAIT_DLY;
                            dly_nxt[i]   = evt.dlytim;
                            set_nxt[i-1] = 1'b0;
                            clr_nxt[i-1] = 1'b1;
                        end
                    end
                    rtos_pkg::EVT_WAIT: begin
                        stat_nxt[i]  = rtos_pkg::WAIT_SEM;
                        set_nxt[i-1] = 1'b0;
                        clr_nxt[i-1] = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // --------------------
    // state registers

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i <= `RTOS_TMAX_TSKID; i++) begin
                tskstat[i] <= rtos_pkg::READY;
            end
            wupcnt <= '0;
            dlycnt <= '0;
            rdq    <= '0;
        end else begin
            tskstat <= stat_nxt;
            wupcnt  <= wup_nxt;
            dlycnt  <= dly_nxt;
            rdq.set <= set_nxt;
            rdq.clr <= clr_nxt;
        end
    end

    // tick prescaler, first pulse PRESCALE cycles out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pscl_cnt  <= PSCL_W'(`RTOS_PRESCALE - 1);
            time_tick <= 1'b0;
        end else begin
            time_tick <= (pscl_cnt == '0);
            if (pscl_cnt == '0) begin
                pscl_cnt <= PSCL_W'(`RTOS_PRESCALE - 1);
            end else begin
                pscl_cnt <= pscl_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/rtos_pkg.sv
logic/rtos_cmd_queue.sv
logic/rtos_object_stage.sv
logic/rtos_task_table.sv
logic/rtos_ready_queue.sv
logic/rtos_core.sv
dv/rtos_core_checker.sv
dv/rtos_core_tb.sv
